/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0
TOP       ?= tb_keypad_top
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Verilator returns a failing status when the run ends in $fatal.
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)

/* sim.f */
+incdir+src
src/keypad_pkg.sv
src/keypad_scanner.sv
src/key_event_fifo.sv
src/keypad_axil_regs.sv
src/keypad_top.sv
test/keypad_matrix_model.sv
test/tb_keypad_top.sv

/* src/key_event_fifo.sv */
`default_nettype none

`include "keypad_defs.svh"

module key_event_fifo
    import keypad_pkg::*;
(
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire                                         push,
    input  wire key_event_t                             push_data,
    input  wire                                         pop,
    input  wire                                         clear_overflow,
    output key_event_t                                  head,
    output logic [$clog2(`KEYPAD_FIFO_DEPTH + 1)-1:0]   count,
    output logic                                        overflow
);

    localparam int DEPTH = `KEYPAD_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);

    key_event_t       mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             do_push;
    logic             do_pop;

    assign do_pop  = pop && (count != '0);
    // A full buffer still takes a push when a pop frees a slot.
    assign do_push = push && ((count != DEPTH) || do_pop);
    assign head    = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until cleared by software.
            if (push && !do_push) begin
                overflow <= 1'b1;
            end else if (clear_overflow) begin
                overflow <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* src/keypad_axil_regs.sv */
`default_nettype none

`include "keypad_defs.svh"

module keypad_axil_regs
    import keypad_pkg::*;
(
    input  wire                                         clk,
    input  wire                                         rst_n,
    input  wire axil_req_t                              axil_req,
    output axil_rsp_t                                   axil_rsp,
    input  wire key_event_t                             head,
    input  wire [$clog2(`KEYPAD_FIFO_DEPTH + 1)-1:0]    count,
    input  wire                                         overflow,
    output logic                                        pop,
    output logic                                        clear_overflow,
    output logic [23:0]                                 debounce_period,
    output logic                                        irq
);

    logic        wr_ready;
    logic        wr_fire;
    logic        bvalid;
    logic        rd_ready;
    logic        rd_fire;
    logic        rvalid;
    logic [31:0] rdata;
    logic [31:0] rd_word;
    logic        irq_en;
    logic        empty;

    assign empty   = (count == '0);
    assign wr_fire = wr_ready && axil_req.awvalid && axil_req.wvalid;
    assign rd_fire = rd_ready && axil_req.arvalid;

    // ******************************
    // Write channels
    // ******************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ready <= 1'b0;
            bvalid   <= 1'b0;
        end else begin
            wr_ready <= !wr_ready && axil_req.awvalid && axil_req.wvalid && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (axil_req.bready) begin
                bvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            debounce_period <= `KEYPAD_DEBOUNCE_RESET;
            irq_en          <= 1'b0;
        end else if (wr_fire) begin
            case (axil_req.awaddr)
                `KEYPAD_REG_DEBOUNCE: debounce_period <= axil_req.wdata[23:0];
                `KEYPAD_REG_CTRL:     irq_en          <= axil_req.wdata[0];
                default:              ;
            endcase
        end
    end

    // Write-one-to-clear, never stored.
    assign clear_overflow = wr_fire && (axil_req.awaddr == `KEYPAD_REG_CTRL) && axil_req.wdata[1];

    // ******************************
    // Read channels
    // ******************************
    always_comb begin
        rd_word = 32'd0;
        case (axil_req.araddr)
            `KEYPAD_REG_STATUS: begin
                rd_word[3:0] = 4'(count);
                rd_word[4]   = empty;
                rd_word[5]   = overflow;
            end
            `KEYPAD_REG_KEY: begin
                if (!empty) begin
                    rd_word[8:0] = {1'b1, head};
                end
            end
            `KEYPAD_REG_DEBOUNCE: rd_word[23:0] = debounce_period;
            `KEYPAD_REG_CTRL:     rd_word[0]    = irq_en;
            default:              rd_word       = 32'd0;
        endcase
    end

    // Head leaves the FIFO on the same edge that captures it.
    assign pop = rd_fire && (axil_req.araddr == `KEYPAD_REG_KEY) && !empty;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_ready <= 1'b0;
            rvalid   <= 1'b0;
        end else begin
            rd_ready <= !rd_ready && axil_req.arvalid && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq <= 1'b0;
        end else begin
            irq <= irq_en && !empty;
        end
    end

    always_comb begin
        axil_rsp         = '0;
        axil_rsp.awready = wr_ready;
        axil_rsp.wready  = wr_ready;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = 2'b00;
        axil_rsp.arready = rd_ready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = 2'b00;
    end

endmodule

`default_nettype wire

/* src/keypad_defs.svh */
`ifndef KEYPAD_DEFS_SVH
`define KEYPAD_DEFS_SVH

// ******************************
// Scanner timing
// ******************************

// Clocks per scan step.
`define KEYPAD_SCAN_DIV 3

// Debounce register value after reset, in scan steps.
`define KEYPAD_DEBOUNCE_RESET 24'd1_000_000

// Number of key events held in the FIFO.
`define KEYPAD_FIFO_DEPTH 8

// ******************************
// Register byte offsets
// ******************************
`define KEYPAD_REG_STATUS   4'h0
`define KEYPAD_REG_KEY      4'h4
`define KEYPAD_REG_DEBOUNCE 4'h8
`define KEYPAD_REG_CTRL     4'hC

`endif

/* src/keypad_pkg.sv */
`default_nettype none

package keypad_pkg;

    // One decoded key press.
    typedef struct packed {
        logic [1:0] row;
        logic [1:0] col;
        logic [3:0] row_pattern;
    } key_event_t;

    // ******************************
    // AXI4-Lite channels
    // ******************************

    // Master to slave.
    typedef struct packed {
        logic [3:0]  awaddr;
        logic        awvalid;
        logic [31:0] wdata;
        logic        wvalid;
        logic        bready;
        logic [3:0]  araddr;
        logic        arvalid;
        logic        rready;
    } axil_req_t;

    // Slave to master.
    typedef struct packed {
        logic        awready;
        logic        wready;
        logic        bvalid;
        logic [1:0]  bresp;
        logic        arready;
        logic        rvalid;
        logic [31:0] rdata;
        logic [1:0]  rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

/* src/keypad_scanner.sv */
`default_nettype none

`include "keypad_defs.svh"

module keypad_scanner
    import keypad_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  wire [3:0]   row_in,
    input  wire [23:0]  debounce_period,
    output logic [3:0]  col_out,
    output key_event_t  key_event,
    output logic        event_valid
);

    localparam int DIV_W = $clog2(`KEYPAD_SCAN_DIV + 1);

    // One-hot state bit positions.
    localparam int S_IDLE    = 0;
    localparam int S_PRESS   = 1;
    localparam int S_WALK0   = 2;
    localparam int S_WALK1   = 3;
    localparam int S_WALK2   = 4;
    localparam int S_WALK3   = 5;
    localparam int S_CONFIRM = 6;
    localparam int S_RELEASE = 7;

    logic [7:0]       state;
    logic [7:0]       state_nxt;
    logic [DIV_W-1:0] step_cnt;
    logic             step;
    logic [23:0]      deb_cnt;
    logic             deb_done;
    logic             rows_low;
    logic             walking;
    logic [1:0]       walk_col;
    logic [1:0]       cap_col;
    logic             hit_found;
    logic             multi;
    logic [1:0]       hit_col;
    logic [3:0]       hit_rows;

    function automatic logic [1:0] walk_index(input logic [7:0] s);
        return {s[S_WALK2] | s[S_WALK3], s[S_WALK1] | s[S_WALK3]};
    endfunction

    function automatic logic one_zero(input logic [3:0] pattern);
        return $countones(~pattern) == 1;
    endfunction

    function automatic logic [1:0] row_index(input logic [3:0] pattern);
        logic [1:0] idx;
        idx = 2'd0;
        for (int i = 0; i < 4; i++) begin
            if (!pattern[i]) begin
                idx = 2'(i);
            end
        end
        return idx;
    endfunction

    assign step     = (step_cnt == DIV_W'(`KEYPAD_SCAN_DIV - 1));
    assign deb_done = ({1'b0, deb_cnt} + 25'd1) >= {1'b0, debounce_period};
    assign rows_low = (row_in != 4'hF);
    assign walking  = |state[S_WALK3:S_WALK0];
    assign walk_col = walk_index(state);
    assign cap_col  = hit_found ? hit_col : walk_col;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            step_cnt <= '0;
        end else if (step) begin
            step_cnt <= '0;
        end else begin
            step_cnt <= step_cnt + 1'b1;
        end
    end

    // ******************************
    // State machine
    // ******************************
    always_comb begin
        state_nxt = state;
        case (1'b1)
            state[S_IDLE]:    if (rows_low) state_nxt = 8'(1) << S_PRESS;
            state[S_PRESS]: begin
                if (deb_done) begin
                    state_nxt = rows_low ? 8'(1) << S_WALK0 : 8'(1) << S_IDLE;
                end
            end
            state[S_WALK0],
            state[S_WALK1],
            state[S_WALK2]:   state_nxt = state << 1;
            state[S_WALK3]: begin
                state_nxt = (hit_found || rows_low) ? 8'(1) << S_CONFIRM : 8'(1) << S_IDLE;
            end
            state[S_CONFIRM]: begin
                if (deb_done) begin
                    state_nxt = rows_low ? 8'(1) << S_RELEASE : 8'(1) << S_IDLE;
                end
            end
            state[S_RELEASE]: if (!rows_low) state_nxt = 8'(1) << S_IDLE;
            default:          state_nxt = 8'(1) << S_IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= 8'(1) << S_IDLE;
            col_out <= 4'b0000;
        end else if (step) begin
            state <= state_nxt;
            if (|state_nxt[S_WALK3:S_WALK0]) begin
                col_out <= ~(4'b0001 << walk_index(state_nxt));
            end else if (state_nxt[S_CONFIRM]) begin
                col_out <= ~(4'b0001 << cap_col);
            end else begin
                col_out <= 4'b0000;
            end
        end
    end

    // Shared by press debounce and confirm.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            deb_cnt <= '0;
        end else if (step) begin
            if ((state[S_PRESS] || state[S_CONFIRM]) && !deb_done) begin
                deb_cnt <= deb_cnt + 1'b1;
            end else begin
                deb_cnt <= '0;
            end
        end
    end

    // A second hit or a multi-row pattern makes the scan ambiguous.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hit_found <= 1'b0;
            multi     <= 1'b0;
        end else if (step) begin
            if (state[S_PRESS]) begin
                hit_found <= 1'b0;
                multi     <= 1'b0;
            end else if (walking && rows_low) begin
                if (hit_found) begin
                    multi <= 1'b1;
                end else begin
                    hit_found <= 1'b1;
                    multi     <= !one_zero(row_in);
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (step && walking && rows_low && !hit_found) begin
            hit_col  <= walk_col;
            hit_rows <= row_in;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            event_valid <= 1'b0;
        end else begin
            event_valid <= step && state[S_CONFIRM] && deb_done && rows_low && !multi;
        end
    end

    always_comb begin
        key_event.row         = row_index(hit_rows);
        key_event.col         = hit_col;
        key_event.row_pattern = hit_rows;
    end

endmodule

`default_nettype wire

/* src/keypad_top.sv */
`default_nettype none

`include "keypad_defs.svh"

module keypad_top
    import keypad_pkg::*;
(
    input  wire             clk,
    input  wire             rst_n,
    input  wire axil_req_t  axil_req,
    output axil_rsp_t       axil_rsp,
    input  wire [3:0]       row_in,
    output logic [3:0]      col_out,
    output logic            irq
);

    localparam int CNT_W = $clog2(`KEYPAD_FIFO_DEPTH + 1);

    key_event_t       scan_event;
    logic             event_valid;
    key_event_t       head;
    logic [CNT_W-1:0] count;
    logic             overflow;
    logic             pop;
    logic             clear_overflow;
    logic [23:0]      debounce_period;

    keypad_scanner scanner_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .row_in          (row_in),
        .debounce_period (debounce_period),
        .col_out         (col_out),
        .key_event       (scan_event),
        .event_valid     (event_valid)
    );

    key_event_fifo fifo_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .push           (event_valid),
        .push_data      (scan_event),
        .pop            (pop),
        .clear_overflow (clear_overflow),
        .head           (head),
        .count          (count),
        .overflow       (overflow)
    );

    keypad_axil_regs regs_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .axil_req        (axil_req),
        .axil_rsp        (axil_rsp),
        .head            (head),
        .count           (count),
        .overflow        (overflow),
        .pop             (pop),
        .clear_overflow  (clear_overflow),
        .debounce_period (debounce_period),
        .irq             (irq)
    );

endmodule

`default_nettype wire

/* test/keypad_matrix_model.sv */
`default_nettype none

module keypad_matrix_model (
    input  wire [3:0]  col_out,
    input  wire [15:0] held,
    output logic [3:0] row_in
);

    timeunit 1ns;
    timeprecision 1ps;

    // Key index is row * 4 + col.
    // A held key pulls its row low while its column is driven low.
    always_comb begin
        row_in = 4'hF;
        for (int r = 0; r < 4; r++) begin
            for (int c = 0; c < 4; c++) begin
                if (held[r * 4 + c] && !col_out[c]) begin
                    row_in[r] = 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* test/tb_keypad_top.sv */
`default_nettype none

`include "keypad_defs.svh"

module tb_keypad_top
    import keypad_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int SCAN_DIV    = `KEYPAD_SCAN_DIV;
    localparam int DEPTH       = `KEYPAD_FIFO_DEPTH;
    localparam int DEBOUNCE    = 4;
    // Clocks from a press until the scanner is idle again.
    localparam int SCAN_CYCLES = (2 * DEBOUNCE + 8) * SCAN_DIV;
    // Worst case for one press, register traffic included.
    localparam int PRESS_CYCLES = SCAN_CYCLES + 96;
    localparam int CYCLE_LIMIT  = 20 * PRESS_CYCLES * 2;
    localparam int SETTLE       = 4 * SCAN_DIV;

    logic        clk = 1'b0;
    logic        rst_n;
    axil_req_t   axil_req;
    axil_rsp_t   axil_rsp;
    logic [3:0]  row_in;
    logic [3:0]  col_out;
    logic        irq;
    logic [15:0] held;
    logic [31:0] rng_state;
    int          cycles = 0;

    keypad_top dut_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .row_in   (row_in),
        .col_out  (col_out),
        .irq      (irq)
    );

    keypad_matrix_model matrix_i (
        .col_out (col_out),
        .held    (held),
        .row_in  (row_in)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run("Timeout: the scenarios did not finish within the cycle limit");
        end
    end

    task automatic abort_run(input string reason);
        $display("Errors found");
        $fatal(1, "%s", reason);
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // Expected event for a set of held keys; none unless exactly one key.
    function automatic logic expected_event(input logic [15:0] keys, output key_event_t ev);
        int idx;
        ev  = '0;
        idx = 0;
        if ($countones(keys) != 1) begin
            return 1'b0;
        end
        for (int i = 0; i < 16; i++) begin
            if (keys[i]) begin
                idx = i;
            end
        end
        ev.row         = 2'(idx / 4);
        ev.col         = 2'(idx % 4);
        ev.row_pattern = ~(4'b0001 << ev.row);
        return 1'b1;
    endfunction

    // ******************************
    // Compare tasks
    // ******************************
    task automatic check_event(input key_event_t actual, input key_event_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run("A key event differs from the reference");
        end
    endtask

    task automatic check_word(input logic [31:0] actual, input logic [31:0] expected,
                              input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
            abort_run("A register word differs from the expected value");
        end
    endtask

    task automatic check_bit(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s, got %b, expected %b", $time, what, actual, expected);
            abort_run("A signal differs from the expected level");
        end
    endtask

    // ******************************
    // AXI4-Lite master
    // ******************************
    task automatic axil_write(input logic [3:0] addr, input logic [31:0] data);
        logic [31:0] r;
        @(posedge clk);
        axil_req.awaddr  <= addr;
        axil_req.wdata   <= data;
        axil_req.awvalid <= 1'b1;
        axil_req.wvalid  <= 1'b1;
        @(posedge clk);
        while (!axil_rsp.awready) begin
            @(posedge clk);
        end
        check_bit(axil_rsp.wready, 1'b1, "WREADY together with AWREADY");
        axil_req.awvalid <= 1'b0;
        axil_req.wvalid  <= 1'b0;
        r = next_random();
        repeat (r[1:0]) @(posedge clk);
        axil_req.bready <= 1'b1;
        @(posedge clk);
        while (!axil_rsp.bvalid) begin
            @(posedge clk);
        end
        check_word(32'(axil_rsp.bresp), 32'h0, "BRESP");
        axil_req.bready <= 1'b0;
    endtask

    task automatic axil_read(input logic [3:0] addr, output logic [31:0] data);
        logic [31:0] r;
        @(posedge clk);
        axil_req.araddr  <= addr;
        axil_req.arvalid <= 1'b1;
        @(posedge clk);
        while (!axil_rsp.arready) begin
            @(posedge clk);
        end
        axil_req.arvalid <= 1'b0;
        r = next_random();
        repeat (r[1:0]) @(posedge clk);
        axil_req.rready <= 1'b1;
        @(posedge clk);
        while (!axil_rsp.rvalid) begin
            @(posedge clk);
        end
        data = axil_rsp.rdata;
        check_word(32'(axil_rsp.rresp), 32'h0, "RRESP");
        axil_req.rready <= 1'b0;
    endtask

    task automatic set_keys(input logic [15:0] keys);
        @(posedge clk);
        held <= keys;
    endtask

    // All rows high for a few scan steps, so the scanner is idle again.
    task automatic release_keys();
        set_keys('0);
        repeat (SETTLE) @(posedge clk);
    endtask

    task automatic poll_status(input logic [31:0] mask, input logic [31:0] value);
        logic [31:0] word;
        axil_read(`KEYPAD_REG_STATUS, word);
        while ((word & mask) != value) begin
            axil_read(`KEYPAD_REG_STATUS, word);
        end
    endtask

    task automatic expect_key(input logic [15:0] keys);
        key_event_t  ev;
        logic        has;
        logic [31:0] word;
        has = expected_event(keys, ev);
        axil_read(`KEYPAD_REG_KEY, word);
        check_bit(word[8], has, "KEY valid flag");
        if (has) begin
            check_event(key_event_t'(word[7:0]), ev, "KEY event");
        end
    endtask

    function automatic logic [15:0] random_key();
        logic [31:0] r;
        r = next_random();
        return 16'h0001 << r[3:0];
    endfunction

    // ******************************
    // Scenarios
    // ******************************
    task automatic check_after_reset();
        logic [31:0] word;
        check_word(32'(col_out), 32'h0, "col_out after reset");
        axil_read(`KEYPAD_REG_STATUS, word);
        check_word(word, 32'h10, "STATUS after reset");
        axil_read(`KEYPAD_REG_DEBOUNCE, word);
        check_word(word, {8'd0, `KEYPAD_DEBOUNCE_RESET}, "DEBOUNCE after reset");
        check_bit(irq, 1'b0, "irq after reset");
        axil_write(`KEYPAD_REG_DEBOUNCE, 32'(DEBOUNCE));
        axil_read(`KEYPAD_REG_DEBOUNCE, word);
        check_word(word, 32'(DEBOUNCE), "DEBOUNCE read back");
    endtask

    task automatic single_presses();
        logic [31:0] word;
        logic [15:0] keys;
        for (int i = 0; i < 16; i++) begin
            keys = random_key();
            set_keys(keys);
            poll_status(32'h0F, 32'h01);
            release_keys();
            expect_key(keys);
            axil_read(`KEYPAD_REG_KEY, word);
            check_word(word, 32'h0, "KEY read with an empty FIFO");
        end
    endtask

    task automatic two_key_press(input logic [15:0] keys);
        logic [31:0] word;
        logic        has;
        key_event_t  ev;
        has = expected_event(keys, ev);
        set_keys(keys);
        repeat (2 * SCAN_CYCLES) @(posedge clk);
        release_keys();
        axil_read(`KEYPAD_REG_STATUS, word);
        check_word(word, has ? 32'h01 : 32'h10, "STATUS after a two-key press");
    endtask

    task automatic long_hold();
        logic [31:0] word;
        logic [15:0] keys;
        keys = random_key();
        set_keys(keys);
        repeat (4 * SCAN_CYCLES) @(posedge clk);
        release_keys();
        axil_read(`KEYPAD_REG_STATUS, word);
        check_word(word, 32'h01, "STATUS after a long hold");
        expect_key(keys);
        axil_read(`KEYPAD_REG_KEY, word);
        check_word(word, 32'h0, "KEY after a long hold");
    endtask

    task automatic fifo_overflow();
        logic [31:0] word;
        logic [15:0] keys;
        logic [15:0] keys_q[$];
        for (int i = 0; i <= DEPTH; i++) begin
            keys = random_key();
            set_keys(keys);
            if (i < DEPTH) begin
                keys_q.push_back(keys);
                poll_status(32'h0F, 32'(i + 1));
            end else begin
                poll_status(32'h20, 32'h20);
            end
            release_keys();
        end
        axil_read(`KEYPAD_REG_STATUS, word);
        check_word(word, 32'(DEPTH) | 32'h20, "STATUS with a full FIFO");
        while (keys_q.size() > 0) begin
            expect_key(keys_q.pop_front());
        end
        axil_write(`KEYPAD_REG_CTRL, 32'h2);
        axil_read(`KEYPAD_REG_STATUS, word);
        check_word(word, 32'h10, "STATUS after overflow clear");
    endtask

    task automatic interrupt();
        logic [15:0] keys;
        axil_write(`KEYPAD_REG_CTRL, 32'h1);
        @(posedge clk);
        check_bit(irq, 1'b0, "irq enabled with an empty FIFO");
        keys = random_key();
        set_keys(keys);
        poll_status(32'h0F, 32'h01);
        @(posedge clk);
        check_bit(irq, 1'b1, "irq with a waiting event");
        release_keys();
        expect_key(keys);
        repeat (2) @(posedge clk);
        check_bit(irq, 1'b0, "irq after the last event was read");
        axil_write(`KEYPAD_REG_CTRL, 32'h0);
        keys = random_key();
        set_keys(keys);
        poll_status(32'h0F, 32'h01);
        repeat (2) @(posedge clk);
        check_bit(irq, 1'b0, "irq while disabled");
        release_keys();
        expect_key(keys);
    endtask

    initial begin
        rst_n     <= 1'b0;
        axil_req  <= '0;
        held      <= '0;
        rng_state = 32'h60ca_9b3a;
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        check_after_reset();
        single_presses();
        // Rows 0 and 1 in columns 1 and 2, then both rows in column 1.
        two_key_press(16'h0042);
        two_key_press(16'h0022);
        long_hold();
        fifo_overflow();
        interrupt();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
